/* common/sa_config.svh */
`ifndef SA_CONFIG_SVH
`define SA_CONFIG_SVH

// ------------------------------------------------------------
// array geometry
// ------------------------------------------------------------
`define SA_NUM_ROW      4       // grid rows, one left bank each
`define SA_NUM_COL      4       // grid columns, one top and one result bank each

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------
`define SA_DATA_WIDTH   8       // operand word
`define SA_ACCU_WIDTH   32      // accumulator, wraps on overflow
`define SA_ADDR_WIDTH   4       // bank address

// words per bank
`define SA_BANK_DEPTH   (1 << `SA_ADDR_WIDTH)

`endif

/* common/sa_pkg.sv */
`include "sa_config.svh"

package sa_pkg;

    // ------------------------------------------------------------
    // datapath types
    // ------------------------------------------------------------
    typedef logic [`SA_DATA_WIDTH-1:0] operand_t;   // unsigned operand
    typedef logic [`SA_ACCU_WIDTH-1:0] accum_t;     // unsigned, modulo 2^32
    typedef logic [`SA_ADDR_WIDTH-1:0] addr_t;      // word address in any bank

    // ------------------------------------------------------------
    // host command
    // ------------------------------------------------------------
    // compute streams the start..end range of both operand groups
    // through the grid and adds onto whatever the cells already hold;
    // flush moves the accumulators into the result banks and clears
    // the grid, one row per cycle
    typedef enum logic [0:0]
    {
        SA_CMD_COMPUTE = 1'b0,  // multiply-accumulate pass
        SA_CMD_FLUSH   = 1'b1   // drain results
    } sa_cmd_e;

endpackage

/* common/sram_port_if.sv */
`timescale 1ns/1ns

interface sram_port_if #(
    parameter type payload_t = logic
);
    import sa_pkg::*;

    logic     en;       // access strobe
    logic     we;       // write when high, read when low
    addr_t    addr;
    payload_t wdata;
    payload_t rdata;    // one cycle after a read, held otherwise

    modport master
    (
        output en, we, addr, wdata,
        input  rdata
    );

    modport slave
    (
        input  en, we, addr, wdata,
        output rdata
    );

endinterface

/* hdl/sram_bank.sv */
`timescale 1ns/1ns
`include "sa_config.svh"

module sram_bank #(
    parameter type payload_t = logic
)
(
    input  logic        clk,
    input  logic        rst_n,
    sram_port_if.slave  port
);

    payload_t mem [`SA_BANK_DEPTH];     // storage array

    // write side
    always_ff @(posedge clk)
    begin
        if (port.en && port.we)
        begin
            mem[port.addr] <= port.wdata;
        end
    end

    // registered read, holds between accesses
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            port.rdata <= '0;
        end
        else if (port.en && !port.we)
        begin
            port.rdata <= mem[port.addr];
        end
    end

endmodule

/* hdl/operand_feeder.sv */
`timescale 1ns/1ns
`include "sa_config.svh"

module operand_feeder #(
    parameter int NUM_LANES = 4
)
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_wr_en,
    input  sa_pkg::addr_t                       i_wr_addr,
    input  logic [NUM_LANES*`SA_DATA_WIDTH-1:0] i_wr_data,
    input  logic                                i_rd_en,
    input  sa_pkg::addr_t                       i_rd_addr,
    output sa_pkg::operand_t [NUM_LANES-1:0]    o_operand,
    output logic [NUM_LANES-1:0]                o_valid
);
    import sa_pkg::*;

    logic [NUM_LANES-1:1] skew_en;                  // delayed strobes, lane 1 up
    addr_t                skew_addr [1:NUM_LANES-1];
    logic [NUM_LANES-1:0] lane_en;                  // strobe seen by each bank
    addr_t                lane_addr [NUM_LANES];
    logic                 wr_ok;                    // host write allowed

    // ------------------------------------------------------------
    // skew line, lane k reads k cycles after lane 0
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            skew_en <= '0;
            for (int k = 1; k < NUM_LANES; k++)
            begin
                skew_addr[k] <= '0;
            end
        end
        else
        begin
            skew_en[1]   <= i_rd_en;
            skew_addr[1] <= i_rd_addr;
            for (int k = 2; k < NUM_LANES; k++)
            begin
                skew_en[k]   <= skew_en[k-1];
                skew_addr[k] <= skew_addr[k-1];
            end
        end
    end

    // valid follows the bank read by one cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_valid <= '0;
        end
        else
        begin
            o_valid <= lane_en;
        end
    end

    assign lane_en = {skew_en, i_rd_en};
    assign wr_ok   = i_wr_en && !(|lane_en);       // reads own the banks

    // ------------------------------------------------------------
    // one bank per lane
    // ------------------------------------------------------------
    for (genvar k = 0; k < NUM_LANES; k++)
    begin : g_lane
        sram_port_if #(.payload_t(operand_t)) bank_if ();

        if (k == 0)
        begin : g_head
            assign lane_addr[k] = i_rd_addr;
        end
        else
        begin : g_tail
            assign lane_addr[k] = skew_addr[k];
        end

        assign bank_if.en    = lane_en[k] || wr_ok;
        assign bank_if.we    = wr_ok;
        assign bank_if.addr  = wr_ok ? i_wr_addr : lane_addr[k];
        assign bank_if.wdata = i_wr_data[k*`SA_DATA_WIDTH +: `SA_DATA_WIDTH];
        assign o_operand[k]  = bank_if.rdata;

        sram_bank #(.payload_t(operand_t)) u_bank
        (
            .clk   (clk),
            .rst_n (rst_n),
            .port  (bank_if.slave)
        );
    end

endmodule

/* hdl/sa_controller.sv */
`timescale 1ns/1ns
`include "sa_config.svh"

module sa_controller
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_cmd_valid,
    input  sa_pkg::sa_cmd_e i_cmd,
    input  sa_pkg::addr_t   i_rd_start_addr,
    input  sa_pkg::addr_t   i_rd_end_addr,
    output logic            o_rd_en,
    output sa_pkg::addr_t   o_rd_addr,
    output logic            o_shift,
    output logic            o_res_wr_en,
    output sa_pkg::addr_t   o_res_wr_addr,
    output logic            o_busy
);
    import sa_pkg::*;

    localparam int DRAIN     = `SA_NUM_ROW + `SA_NUM_COL + 2;   // last operands cross grid
    localparam int CNT_WIDTH = $clog2(DRAIN);

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_COMPUTE,
        ST_FLUSH
    } state_e;

    state_e               state;
    addr_t                addr_cnt;     // read address, or flush step
    addr_t                end_addr;
    logic                 rd_active;
    logic [CNT_WIDTH-1:0] drain_cnt;
    logic                 accept;

    assign accept = i_cmd_valid && (state == ST_IDLE);  // dropped while busy

    // ------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= ST_IDLE;
            addr_cnt  <= '0;
            end_addr  <= '0;
            rd_active <= 1'b0;
            drain_cnt <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (accept && i_cmd == SA_CMD_COMPUTE)
                    begin
                        state     <= ST_COMPUTE;
                        addr_cnt  <= i_rd_start_addr;
                        end_addr  <= i_rd_end_addr;
                        rd_active <= 1'b1;
                    end
                    else if (accept)
                    begin
                        state    <= ST_FLUSH;
                        addr_cnt <= '0;
                    end
                end
                ST_COMPUTE:
                begin
                    if (rd_active)
                    begin
                        if (addr_cnt == end_addr)
                        begin
                            rd_active <= 1'b0;
                            drain_cnt <= CNT_WIDTH'(DRAIN - 1);
                        end
                        else
                        begin
                            addr_cnt <= addr_cnt + 1'b1;
                        end
                    end
                    else if (drain_cnt == '0)
                    begin
                        state <= ST_IDLE;
                    end
                    else
                    begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                ST_FLUSH:
                begin
                    if (addr_cnt == addr_t'(`SA_NUM_ROW - 1))
                    begin
                        state <= ST_IDLE;
                    end
                    addr_cnt <= addr_cnt + 1'b1;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign o_rd_en       = rd_active;
    assign o_rd_addr     = addr_cnt;
    assign o_shift       = (state == ST_FLUSH);     // one row per cycle
    assign o_res_wr_en   = (state == ST_FLUSH);     // bottom row before the shift
    assign o_res_wr_addr = addr_cnt;
    assign o_busy        = (state != ST_IDLE);

    // the read counter only counts up
    a_range_order: assert property (@(posedge clk) disable iff (!rst_n)
        (accept && i_cmd == SA_CMD_COMPUTE) |-> (i_rd_start_addr <= i_rd_end_addr));

endmodule

/* pe_array/pe_cell.sv */
`timescale 1ns/1ns

module pe_cell
(
    input  logic             clk,
    input  logic             rst_n,
    input  sa_pkg::operand_t i_a,
    input  logic             i_a_valid,
    input  sa_pkg::operand_t i_b,
    input  logic             i_b_valid,
    input  logic             i_shift,
    input  sa_pkg::accum_t   i_accum_in,
    output sa_pkg::operand_t o_a,
    output logic             o_a_valid,
    output sa_pkg::operand_t o_b,
    output logic             o_b_valid,
    output sa_pkg::accum_t   o_accum
);
    import sa_pkg::*;

    accum_t product;

    assign product = accum_t'(i_a) * accum_t'(i_b);    // full 16-bit product

    // operands move on right and down
    always_ff @(posedge clk)
    begin
        o_a <= i_a;
        o_b <= i_b;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_a_valid <= 1'b0;
            o_b_valid <= 1'b0;
            o_accum   <= '0;
        end
        else
        begin
            o_a_valid <= i_a_valid;
            o_b_valid <= i_b_valid;
            if (i_shift)
            begin
                o_accum <= i_accum_in;                 // take the cell above
            end
            else if (i_a_valid && i_b_valid)
            begin
                o_accum <= o_accum + product;          // wraps mod 2^32
            end
        end
    end

    // row and column skew must land both operands here together
    a_valid_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        i_a_valid == i_b_valid);

endmodule

/* pe_array/pe_array.sv */
`timescale 1ns/1ns
`include "sa_config.svh"

module pe_array
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  sa_pkg::operand_t [`SA_NUM_ROW-1:0] i_left_operand,
    input  logic [`SA_NUM_ROW-1:0]             i_left_valid,
    input  sa_pkg::operand_t [`SA_NUM_COL-1:0] i_top_operand,
    input  logic [`SA_NUM_COL-1:0]             i_top_valid,
    input  logic                               i_shift,
    output sa_pkg::accum_t [`SA_NUM_COL-1:0]   o_bottom_accum
);
    import sa_pkg::*;

    // the last column and last row of the buses fall off the edge
    operand_t a_bus   [`SA_NUM_ROW][`SA_NUM_COL+1];
    logic     a_valid [`SA_NUM_ROW][`SA_NUM_COL+1];
    operand_t b_bus   [`SA_NUM_ROW+1][`SA_NUM_COL];
    logic     b_valid [`SA_NUM_ROW+1][`SA_NUM_COL];
    accum_t   accum   [`SA_NUM_ROW][`SA_NUM_COL];

    for (genvar r = 0; r < `SA_NUM_ROW; r++)
    begin : g_left
        assign a_bus[r][0]   = i_left_operand[r];
        assign a_valid[r][0] = i_left_valid[r];
    end

    for (genvar c = 0; c < `SA_NUM_COL; c++)
    begin : g_top
        assign b_bus[0][c]       = i_top_operand[c];
        assign b_valid[0][c]     = i_top_valid[c];
        assign o_bottom_accum[c] = accum[`SA_NUM_ROW-1][c];
    end

    // ------------------------------------------------------------
    // cell grid
    // ------------------------------------------------------------
    for (genvar r = 0; r < `SA_NUM_ROW; r++)
    begin : g_row
        for (genvar c = 0; c < `SA_NUM_COL; c++)
        begin : g_col
            accum_t accum_above;

            if (r == 0)
            begin : g_first
                assign accum_above = '0;            // zero shifts into the top row
            end
            else
            begin : g_inner
                assign accum_above = accum[r-1][c];
            end

            pe_cell u_cell
            (
                .clk        (clk),
                .rst_n      (rst_n),
                .i_a        (a_bus[r][c]),
                .i_a_valid  (a_valid[r][c]),
                .i_b        (b_bus[r][c]),
                .i_b_valid  (b_valid[r][c]),
                .i_shift    (i_shift),
                .i_accum_in (accum_above),
                .o_a        (a_bus[r][c+1]),
                .o_a_valid  (a_valid[r][c+1]),
                .o_b        (b_bus[r+1][c]),
                .o_b_valid  (b_valid[r+1][c]),
                .o_accum    (accum[r][c])
            );
        end
    end

endmodule

/* hdl/systolic_array_top.sv */
`timescale 1ns/1ns
`include "sa_config.svh"

module systolic_array_top
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  i_top_wr_en,
    input  sa_pkg::addr_t                         i_top_wr_addr,
    input  logic [`SA_NUM_COL*`SA_DATA_WIDTH-1:0] i_top_wr_data,
    input  logic                                  i_left_wr_en,
    input  sa_pkg::addr_t                         i_left_wr_addr,
    input  logic [`SA_NUM_ROW*`SA_DATA_WIDTH-1:0] i_left_wr_data,
    input  logic                                  i_cmd_valid,
    input  sa_pkg::sa_cmd_e                       i_cmd,
    input  sa_pkg::addr_t                         i_rd_start_addr,
    input  sa_pkg::addr_t                         i_rd_end_addr,
    input  logic                                  i_down_rd_en,
    input  sa_pkg::addr_t                         i_down_rd_addr,
    output logic [`SA_NUM_COL*`SA_ACCU_WIDTH-1:0] o_down_rd_data,
    output logic                                  o_busy
);
    import sa_pkg::*;

    logic                       rd_en;          // shared by both operand groups
    addr_t                      rd_addr;
    logic                       shift;
    logic                       res_wr_en;
    addr_t                      res_wr_addr;
    operand_t [`SA_NUM_COL-1:0] top_operand;
    logic [`SA_NUM_COL-1:0]     top_valid;
    operand_t [`SA_NUM_ROW-1:0] left_operand;
    logic [`SA_NUM_ROW-1:0]     left_valid;
    accum_t [`SA_NUM_COL-1:0]   bottom_accum;

    sa_controller u_ctrl
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_cmd_valid     (i_cmd_valid),
        .i_cmd           (i_cmd),
        .i_rd_start_addr (i_rd_start_addr),
        .i_rd_end_addr   (i_rd_end_addr),
        .o_rd_en         (rd_en),
        .o_rd_addr       (rd_addr),
        .o_shift         (shift),
        .o_res_wr_en     (res_wr_en),
        .o_res_wr_addr   (res_wr_addr),
        .o_busy          (o_busy)
    );

    // ------------------------------------------------------------
    // operand groups, columns on top and rows on the left
    // ------------------------------------------------------------
    operand_feeder #(.NUM_LANES(`SA_NUM_COL)) u_top_feeder
    (
        .clk (clk), .rst_n (rst_n),
        .i_wr_en (i_top_wr_en), .i_wr_addr (i_top_wr_addr), .i_wr_data (i_top_wr_data),
        .i_rd_en (rd_en), .i_rd_addr (rd_addr),
        .o_operand (top_operand), .o_valid (top_valid)
    );

    operand_feeder #(.NUM_LANES(`SA_NUM_ROW)) u_left_feeder
    (
        .clk (clk), .rst_n (rst_n),
        .i_wr_en (i_left_wr_en), .i_wr_addr (i_left_wr_addr), .i_wr_data (i_left_wr_data),
        .i_rd_en (rd_en), .i_rd_addr (rd_addr),
        .o_operand (left_operand), .o_valid (left_valid)
    );

    pe_array u_pe_array
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_left_operand (left_operand),
        .i_left_valid   (left_valid),
        .i_top_operand  (top_operand),
        .i_top_valid    (top_valid),
        .i_shift        (shift),
        .o_bottom_accum (bottom_accum)
    );

    // ------------------------------------------------------------
    // result banks, flush writes take the port over host reads
    // ------------------------------------------------------------
    for (genvar c = 0; c < `SA_NUM_COL; c++)
    begin : g_res
        sram_port_if #(.payload_t(accum_t)) res_if ();

        assign res_if.en    = res_wr_en || i_down_rd_en;
        assign res_if.we    = res_wr_en;
        assign res_if.addr  = res_wr_en ? res_wr_addr : i_down_rd_addr;
        assign res_if.wdata = bottom_accum[c];
        assign o_down_rd_data[c*`SA_ACCU_WIDTH +: `SA_ACCU_WIDTH] = res_if.rdata;

        sram_bank #(.payload_t(accum_t)) u_res_bank
        (
            .clk   (clk),
            .rst_n (rst_n),
            .port  (res_if.slave)
        );
    end

endmodule

/* testbench/tb_systolic_array.sv */
`timescale 1ns/1ns
`include "sa_config.svh"

module tb_systolic_array;
    import sa_pkg::*;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  i_top_wr_en;
    addr_t                                 i_top_wr_addr;
    logic [`SA_NUM_COL*`SA_DATA_WIDTH-1:0] i_top_wr_data;
    logic                                  i_left_wr_en;
    addr_t                                 i_left_wr_addr;
    logic [`SA_NUM_ROW*`SA_DATA_WIDTH-1:0] i_left_wr_data;
    logic                                  i_cmd_valid;
    sa_cmd_e                               i_cmd;
    addr_t                                 i_rd_start_addr;
    addr_t                                 i_rd_end_addr;
    logic                                  i_down_rd_en;
    addr_t                                 i_down_rd_addr;
    logic [`SA_NUM_COL*`SA_ACCU_WIDTH-1:0] o_down_rd_data;
    logic                                  o_busy;

    integer   seed;
    operand_t top_mem   [`SA_BANK_DEPTH][`SA_NUM_COL];  // copy of the top banks
    operand_t left_mem  [`SA_BANK_DEPTH][`SA_NUM_ROW];  // copy of the left banks
    accum_t   model_c   [`SA_NUM_ROW][`SA_NUM_COL];     // expected grid contents
    accum_t   model_res [`SA_NUM_ROW][`SA_NUM_COL];     // [result addr][column]

    systolic_array_top UUT
    (
        .clk (clk), .rst_n (rst_n),
        .i_top_wr_en (i_top_wr_en), .i_top_wr_addr (i_top_wr_addr),
        .i_top_wr_data (i_top_wr_data),
        .i_left_wr_en (i_left_wr_en), .i_left_wr_addr (i_left_wr_addr),
        .i_left_wr_data (i_left_wr_data),
        .i_cmd_valid (i_cmd_valid), .i_cmd (i_cmd),
        .i_rd_start_addr (i_rd_start_addr), .i_rd_end_addr (i_rd_end_addr),
        .i_down_rd_en (i_down_rd_en), .i_down_rd_addr (i_down_rd_addr),
        .o_down_rd_data (o_down_rd_data), .o_busy (o_busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // checking and waiting
    // ------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAIL time=%0t %s got=%h expected=%h",
                                $time, name, actual, expected));
        end
    endtask

    // polls o_busy on falling edges until it reaches the level
    task automatic wait_busy(input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (o_busy !== level)
        begin
            if (cycles >= limit)
            begin
                abort_run($sformatf("timeout after %0d cycles waiting for %s", cycles, what));
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic fill_operands();
        logic [31:0]                           rnd;
        logic [`SA_NUM_COL*`SA_DATA_WIDTH-1:0] top_word;
        logic [`SA_NUM_ROW*`SA_DATA_WIDTH-1:0] left_word;
        for (int a = 0; a < `SA_BANK_DEPTH; a++)
        begin
            for (int c = 0; c < `SA_NUM_COL; c++)
            begin
                rnd = $random(seed);
                top_mem[a][c] = rnd[`SA_DATA_WIDTH-1:0];
                top_word[c*`SA_DATA_WIDTH +: `SA_DATA_WIDTH] = rnd[`SA_DATA_WIDTH-1:0];
            end
            for (int r = 0; r < `SA_NUM_ROW; r++)
            begin
                rnd = $random(seed);
                left_mem[a][r] = rnd[`SA_DATA_WIDTH-1:0];
                left_word[r*`SA_DATA_WIDTH +: `SA_DATA_WIDTH] = rnd[`SA_DATA_WIDTH-1:0];
            end
            @(posedge clk);
            i_top_wr_en    <= 1'b1;
            i_top_wr_addr  <= addr_t'(a);
            i_top_wr_data  <= top_word;
            i_left_wr_en   <= 1'b1;
            i_left_wr_addr <= addr_t'(a);
            i_left_wr_data <= left_word;
        end
        @(posedge clk);
        i_top_wr_en  <= 1'b0;
        i_left_wr_en <= 1'b0;
    endtask

    // one-cycle command pulse
    task automatic issue_cmd(input sa_cmd_e cmd, input int lo, input int hi);
        @(posedge clk);
        i_cmd_valid     <= 1'b1;
        i_cmd           <= cmd;
        i_rd_start_addr <= addr_t'(lo);
        i_rd_end_addr   <= addr_t'(hi);
        @(posedge clk);
        i_cmd_valid <= 1'b0;
    endtask

    task automatic model_compute(input int lo, input int hi);
        for (int a = lo; a <= hi; a++)
        begin
            for (int r = 0; r < `SA_NUM_ROW; r++)
            begin
                for (int c = 0; c < `SA_NUM_COL; c++)
                begin
                    model_c[r][c] = model_c[r][c]
                                  + accum_t'(left_mem[a][r]) * accum_t'(top_mem[a][c]);
                end
            end
        end
    endtask

    // bottom row leaves first and the grid ends up cleared
    task automatic model_flush();
        for (int k = 0; k < `SA_NUM_ROW; k++)
        begin
            for (int c = 0; c < `SA_NUM_COL; c++)
            begin
                model_res[k][c] = model_c[`SA_NUM_ROW-1-k][c];
                model_c[`SA_NUM_ROW-1-k][c] = '0;
            end
        end
    endtask

    task automatic run_compute(input int lo, input int hi);
        issue_cmd(SA_CMD_COMPUTE, lo, hi);
        model_compute(lo, hi);
        wait_busy(1'b1, 4, "busy after compute command");
        wait_busy(1'b0, hi - lo + `SA_NUM_ROW + `SA_NUM_COL + 8, "end of compute");
    endtask

    task automatic run_flush();
        issue_cmd(SA_CMD_FLUSH, 0, 0);
        model_flush();
        wait_busy(1'b1, 4, "busy after flush command");
        wait_busy(1'b0, `SA_NUM_ROW + 4, "end of flush");
    endtask

    task automatic check_results();
        for (int k = 0; k < `SA_NUM_ROW; k++)
        begin
            @(posedge clk);
            i_down_rd_en   <= 1'b1;
            i_down_rd_addr <= addr_t'(k);
            @(posedge clk);
            i_down_rd_en <= 1'b0;
            @(negedge clk);                             // data settled a cycle after
            for (int c = 0; c < `SA_NUM_COL; c++)
            begin
                compare_value($sformatf("o_down_rd_data[%0d] addr %0d", c, k),
                              o_down_rd_data[c*`SA_ACCU_WIDTH +: `SA_ACCU_WIDTH],
                              model_res[k][c]);
            end
        end
    endtask

    task automatic pick_range(output int lo, output int hi);
        logic [31:0] rnd;
        rnd = $random(seed);
        lo  = 1 + int'(rnd % 15);                       // nonzero start
        rnd = $random(seed);
        hi  = lo + int'(rnd % (`SA_BANK_DEPTH - lo));
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial
    begin
        int lo;
        int hi;
        seed            = 32'hca0f32e7;
        rst_n           = 1'b0;
        i_top_wr_en     = 1'b0;
        i_top_wr_addr   = '0;
        i_top_wr_data   = '0;
        i_left_wr_en    = 1'b0;
        i_left_wr_addr  = '0;
        i_left_wr_data  = '0;
        i_cmd_valid     = 1'b0;
        i_cmd           = SA_CMD_COMPUTE;
        i_rd_start_addr = '0;
        i_rd_end_addr   = '0;
        i_down_rd_en    = 1'b0;
        i_down_rd_addr  = '0;
        for (int r = 0; r < `SA_NUM_ROW; r++)
        begin
            for (int c = 0; c < `SA_NUM_COL; c++)
            begin
                model_c[r][c] = '0;
            end
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_value("o_busy", 32'(o_busy), 0);       // idle out of reset

        // one pass over the full range
        fill_operands();
        run_compute(0, `SA_BANK_DEPTH - 1);
        run_flush();
        check_results();

        // two partial passes add up before one flush
        fill_operands();
        pick_range(lo, hi);
        run_compute(lo, hi);
        pick_range(lo, hi);
        run_compute(lo, hi);
        run_flush();
        check_results();

        // nothing computed since the last flush
        run_flush();
        check_results();

        // flush sent mid-compute must be dropped
        pick_range(lo, hi);
        issue_cmd(SA_CMD_COMPUTE, lo, hi);
        model_compute(lo, hi);
        wait_busy(1'b1, 4, "busy after compute command");
        issue_cmd(SA_CMD_FLUSH, 0, 0);
        wait_busy(1'b0, hi - lo + `SA_NUM_ROW + `SA_NUM_COL + 8, "end of compute");
        repeat (3) @(negedge clk);
        compare_value("o_busy", 32'(o_busy), 0);
        run_flush();
        check_results();

        $display("Test passed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+common
common/sa_pkg.sv
common/sram_port_if.sv
hdl/sram_bank.sv
hdl/operand_feeder.sv
hdl/sa_controller.sv
pe_array/pe_cell.sv
pe_array/pe_array.sv
hdl/systolic_array_top.sv
testbench/tb_systolic_array.sv

/* Makefile */
# Verilator build and run for the systolic array testbench

VERILATOR ?= verilator
TOP       ?= tb_systolic_array
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard common/*.sv common/*.svh hdl/*.sv pe_array/*.sv testbench/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
